// ==== Bender.yml ====
package:
  name: two_way_cache

sources:
  - common/cache_pkg.sv
  - rtl/addr_decode.sv
  - cache_array/lru_array.sv
  - cache_array/tag_array.sv
  - cache_array/data_array.sv
  - rtl/cache_ctrl.sv
  - rtl/two_way_cache.sv
  - target: simulation
    files:
      - tb/two_way_cache_chk.sv
      - tb/two_way_cache_tb.sv

// ==== cache_array/data_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_array #(
	parameter int num_sets = cache_pkg::num_sets,
	parameter int words_per_block = cache_pkg::words_per_block
) (
	input  logic clk,
	input  logic [num_sets-1:0] set_onehot,
	input  logic [words_per_block-1:0] word_onehot,
	input  logic read_way,
	input  logic data_we,
	input  logic write_way,
	input  logic [cache_pkg::data_w-1:0] wdata,
	output logic [cache_pkg::data_w-1:0] rdata
);

	import cache_pkg::*;

	// two ways, each num_sets blocks of words_per_block words
	logic [data_w-1:0] mem [2][num_sets][words_per_block];

	// one word per cycle, picked by the set and word selects together
	always_ff @(posedge clk) begin
		if (data_we) begin
			for (int s = 0; s < num_sets; s++) begin
				for (int w = 0; w < words_per_block; w++) begin
					if (set_onehot[s] && word_onehot[w]) begin
						mem[write_way][s][w] <= wdata;
					end
				end
			end
		end
	end

	// asynchronous read so a hit can be answered out of the lookup cycle
	// the selects are one-hot, so only one word reaches the or
	always_comb begin
		rdata = '0;
		for (int s = 0; s < num_sets; s++) begin
			for (int w = 0; w < words_per_block; w++) begin
				if (set_onehot[s] && word_onehot[w]) begin
					rdata = rdata | mem[read_way][s][w];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== cache_array/lru_array.sv ====
`timescale 1ns/10ps
`default_nettype none

// one replacement bit per set
// a bit of 0 means way 0 is the least recently used, 1 means way 1
module lru_array #(
	parameter int num_sets = cache_pkg::num_sets
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [num_sets-1:0] set_onehot,
	input  logic lru_we,
	input  logic used_way,
	output logic lru_way
);

	logic [num_sets-1:0] lru_q;

	// the way just used becomes most recent, so the other way is stored
	// as the next one to go
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lru_q <= '0;
		end else if (lru_we) begin
			lru_q <= (lru_q & ~set_onehot) | (set_onehot & {num_sets{~used_way}});
		end
	end

	// only the selected set survives the mask, so or-reducing the masked
	// bits reads that set's bit out
	assign lru_way = |(lru_q & set_onehot);

endmodule

`default_nettype wire

// ==== cache_array/tag_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module tag_array #(
	parameter int num_sets = cache_pkg::num_sets
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [num_sets-1:0] set_onehot,
	input  logic [cache_pkg::tag_w-1:0] tag,
	input  logic lru_way,
	input  logic tag_we,
	input  logic write_way,
	output logic hit,
	output logic hit_way,
	output logic victim_way
);

	import cache_pkg::*;

	// valid bits per way, cleared on reset so the whole cache starts empty
	logic [1:0][num_sets-1:0] valid_q;
	logic [tag_w-1:0] tag_mem [2][num_sets];

	// contents of the selected set for both ways
	logic [1:0] valid_rd;
	logic [1:0][tag_w-1:0] tag_rd;
	logic [1:0] way_hit;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (tag_we) begin
			valid_q[write_way] <= valid_q[write_way] | set_onehot;
		end
	end

	// tag store, only ever read behind its valid bit
	always_ff @(posedge clk) begin
		if (tag_we) begin
			for (int s = 0; s < num_sets; s++) begin
				if (set_onehot[s]) begin
					tag_mem[write_way][s] <= tag;
				end
			end
		end
	end

	// one-hot read, at most one set contributes to each or
	always_comb begin
		valid_rd = '0;
		tag_rd = '0;
		for (int s = 0; s < num_sets; s++) begin
			if (set_onehot[s]) begin
				valid_rd[0] = valid_rd[0] | valid_q[0][s];
				valid_rd[1] = valid_rd[1] | valid_q[1][s];
				tag_rd[0] = tag_rd[0] | tag_mem[0][s];
				tag_rd[1] = tag_rd[1] | tag_mem[1][s];
			end
		end
	end

	// both ways compared side by side
	assign way_hit[0] = valid_rd[0] && (tag_rd[0] == tag);
	assign way_hit[1] = valid_rd[1] && (tag_rd[1] == tag);
	assign hit = |way_hit;
	// a tag lives in one way only, so way 1 hitting decides the index
	assign hit_way = way_hit[1];

	// empty ways are filled first, way 0 before way 1, then the lru way
	assign victim_way = !valid_rd[0] ? 1'b0 : (!valid_rd[1] ? 1'b1 : lru_way);

endmodule

`default_nettype wire

// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// address split of the 16-bit word address: tag, set index, word offset
	localparam int tag_w = 7;
	localparam int set_w = 6;
	localparam int offset_w = 3;
	localparam int addr_w = tag_w + set_w + offset_w;
	// the block address is everything above the word offset
	localparam int block_w = tag_w + set_w;

	localparam int data_w = 16;
	localparam int num_sets = 64;
	localparam int words_per_block = 8;

	// lookup view, the tag sits in the upper bits as in a plain split
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [set_w-1:0] set;
		logic [offset_w-1:0] offset;
	} addr_fields_t;

	// fill view, memory is addressed by whole blocks
	typedef struct packed {
		logic [block_w-1:0] block;
		logic [offset_w-1:0] offset;
	} addr_block_t;

	// one request address, read either per field or per block
	typedef union packed {
		addr_fields_t fields;
		addr_block_t blk;
	} cache_addr_u;

	// controller states, one request in flight at a time
	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_fill_req,
		st_fill_data,
		st_write_mem,
		st_respond
	} ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/addr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module addr_decode #(
	parameter int num_sets = cache_pkg::num_sets,
	parameter int words_per_block = cache_pkg::words_per_block
) (
	input  cache_pkg::cache_addr_u addr,
	output logic [cache_pkg::tag_w-1:0] tag,
	output logic [num_sets-1:0] set_onehot,
	output logic [words_per_block-1:0] word_onehot
);

	localparam int set_sel_w = $clog2(num_sets);
	localparam int word_sel_w = $clog2(words_per_block);

	logic [set_sel_w-1:0] set_idx;
	logic [word_sel_w-1:0] word_idx;

	assign tag = addr.fields.tag;
	assign set_idx = addr.fields.set;
	assign word_idx = addr.fields.offset;

	// start from a single one in bit 0 and let each index bit, msb first,
	// push it up by its binary weight, one stage per bit
	always_comb begin
		set_onehot = '0;
		set_onehot[0] = 1'b1;
		for (int i = set_sel_w - 1; i >= 0; i--) begin
			if (set_idx[i]) begin
				set_onehot = set_onehot << (1 << i);
			end
		end
	end

	// same shift stages for the word inside the block
	always_comb begin
		word_onehot = '0;
		word_onehot[0] = 1'b1;
		for (int i = word_sel_w - 1; i >= 0; i--) begin
			if (word_idx[i]) begin
				word_onehot = word_onehot << (1 << i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid,
	output logic req_ready,
	input  logic req_we,
	input  logic [cache_pkg::addr_w-1:0] req_addr,
	input  logic [cache_pkg::data_w-1:0] req_wdata,
	output logic resp_valid,
	output logic [cache_pkg::data_w-1:0] resp_rdata,
	output logic mem_rd_valid,
	input  logic mem_rd_ready,
	output logic [cache_pkg::block_w-1:0] mem_rd_addr,
	input  logic mem_fill_valid,
	input  logic [cache_pkg::data_w-1:0] mem_fill_data,
	output logic mem_wr_valid,
	input  logic mem_wr_ready,
	output logic [cache_pkg::addr_w-1:0] mem_wr_addr,
	output logic [cache_pkg::data_w-1:0] mem_wr_data,
	input  logic hit,
	input  logic hit_way,
	input  logic victim_way,
	output logic [cache_pkg::offset_w-1:0] fill_word,
	output cache_pkg::cache_addr_u addr_q,
	output logic tag_we,
	output logic data_we,
	output logic write_way,
	output logic read_way,
	output logic lru_we,
	output logic used_way,
	output logic [cache_pkg::data_w-1:0] array_wdata,
	input  logic [cache_pkg::data_w-1:0] array_rdata
);

	import cache_pkg::*;

	localparam logic [offset_w-1:0] last_word = offset_w'(words_per_block - 1);

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic [offset_w-1:0] beat_q;
	logic we_q;
	logic victim_q;
	logic [data_w-1:0] wdata_q;
	logic [data_w-1:0] rdata_q;

	logic in_lookup;
	logic in_fill;
	logic fill_beat;
	logic fill_done;

	assign in_lookup = (state_q == st_lookup);
	assign in_fill = (state_q == st_fill_data);
	assign fill_beat = in_fill && mem_fill_valid;
	assign fill_done = fill_beat && (beat_q == last_word);

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle:      if (req_valid) state_d = st_lookup;
			// writes always go to memory, hit or not
			st_lookup:    state_d = we_q ? st_write_mem : (hit ? st_respond : st_fill_req);
			st_fill_req:  if (mem_rd_ready) state_d = st_fill_data;
			st_fill_data: if (fill_done) state_d = st_respond;
			st_write_mem: if (mem_wr_ready) state_d = st_respond;
			st_respond:   state_d = st_idle;
			default:      state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= st_idle;
			beat_q <= '0;
		end else begin
			state_q <= state_d;
			// beats arrive in word order, so the counter is the word index
			if (state_q == st_fill_req) begin
				beat_q <= '0;
			end else if (fill_beat) begin
				beat_q <= beat_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		// the request is held here for its whole lifetime
		if (req_valid && req_ready) begin
			addr_q <= req_addr;
			wdata_q <= req_wdata;
			we_q <= req_we;
		end
		// the way to fill has to stay fixed across all eight beats
		if (in_lookup) begin
			victim_q <= victim_way;
		end
		// a write response carries zero, a read hit takes the array word
		if (in_lookup && we_q) begin
			rdata_q <= '0;
		end else if (in_lookup && hit) begin
			rdata_q <= array_rdata;
		end else if (fill_beat && (beat_q == addr_q.fields.offset)) begin
			rdata_q <= mem_fill_data;
		end
	end

	assign req_ready = (state_q == st_idle);
	assign resp_valid = (state_q == st_respond);
	assign resp_rdata = rdata_q;

	// both memory requests hold their address from the request register
	assign mem_rd_valid = (state_q == st_fill_req);
	assign mem_rd_addr = addr_q.blk.block;
	assign mem_wr_valid = (state_q == st_write_mem);
	assign mem_wr_addr = addr_q;
	assign mem_wr_data = wdata_q;

	// during a fill the beat counter overrides the requested word offset
	assign fill_word = in_fill ? beat_q : addr_q.fields.offset;

	// the tag goes valid only once the last word of the block is in
	assign tag_we = fill_done;
	assign data_we = (in_lookup && hit && we_q) || fill_beat;
	assign write_way = in_fill ? victim_q : hit_way;
	assign array_wdata = in_fill ? mem_fill_data : wdata_q;
	assign read_way = hit_way;

	// every hit and every completed fill refreshes the set's lru bit
	assign lru_we = (in_lookup && hit) || fill_done;
	assign used_way = in_fill ? victim_q : hit_way;

endmodule

`default_nettype wire

// ==== rtl/two_way_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module two_way_cache #(
	parameter int num_sets = cache_pkg::num_sets,
	parameter int words_per_block = cache_pkg::words_per_block
) (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid,
	output logic req_ready,
	input  logic req_we,
	input  logic [cache_pkg::addr_w-1:0] req_addr,
	input  logic [cache_pkg::data_w-1:0] req_wdata,
	output logic resp_valid,
	output logic [cache_pkg::data_w-1:0] resp_rdata,
	output logic mem_rd_valid,
	input  logic mem_rd_ready,
	output logic [cache_pkg::block_w-1:0] mem_rd_addr,
	input  logic mem_fill_valid,
	input  logic [cache_pkg::data_w-1:0] mem_fill_data,
	output logic mem_wr_valid,
	input  logic mem_wr_ready,
	output logic [cache_pkg::addr_w-1:0] mem_wr_addr,
	output logic [cache_pkg::data_w-1:0] mem_wr_data
);

	import cache_pkg::*;

	cache_addr_u addr_q;
	cache_addr_u dec_addr;
	logic [offset_w-1:0] fill_word;
	logic [tag_w-1:0] tag;
	logic [num_sets-1:0] set_onehot;
	logic [words_per_block-1:0] word_onehot;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic lru_way;
	logic tag_we;
	logic data_we;
	logic write_way;
	logic read_way;
	logic lru_we;
	logic used_way;
	logic [data_w-1:0] array_wdata;
	logic [data_w-1:0] array_rdata;

	// the block part always comes from the held request and the word part
	// from the controller, which swaps in the beat counter during a fill
	assign dec_addr = {addr_q.blk.block, fill_word};

	addr_decode #(
		.num_sets(num_sets),
		.words_per_block(words_per_block)
	) i_addr_decode (
		.addr(dec_addr), .tag(tag), .set_onehot(set_onehot), .word_onehot(word_onehot)
	);

	lru_array #(
		.num_sets(num_sets)
	) i_lru_array (
		.clk(clk), .rst_n(rst_n), .set_onehot(set_onehot), .lru_we(lru_we),
		.used_way(used_way), .lru_way(lru_way)
	);

	tag_array #(
		.num_sets(num_sets)
	) i_tag_array (
		.clk(clk), .rst_n(rst_n), .set_onehot(set_onehot), .tag(tag), .lru_way(lru_way),
		.tag_we(tag_we), .write_way(write_way), .hit(hit), .hit_way(hit_way),
		.victim_way(victim_way)
	);

	data_array #(
		.num_sets(num_sets),
		.words_per_block(words_per_block)
	) i_data_array (
		.clk(clk), .set_onehot(set_onehot), .word_onehot(word_onehot), .read_way(read_way),
		.data_we(data_we), .write_way(write_way), .wdata(array_wdata), .rdata(array_rdata)
	);

	cache_ctrl i_cache_ctrl (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_ready(req_ready), .req_we(req_we),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.resp_valid(resp_valid), .resp_rdata(resp_rdata),
		.mem_rd_valid(mem_rd_valid), .mem_rd_ready(mem_rd_ready), .mem_rd_addr(mem_rd_addr),
		.mem_fill_valid(mem_fill_valid), .mem_fill_data(mem_fill_data),
		.mem_wr_valid(mem_wr_valid), .mem_wr_ready(mem_wr_ready),
		.mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.fill_word(fill_word), .addr_q(addr_q),
		.tag_we(tag_we), .data_we(data_we), .write_way(write_way), .read_way(read_way),
		.lru_we(lru_we), .used_way(used_way),
		.array_wdata(array_wdata), .array_rdata(array_rdata)
	);

endmodule

`default_nettype wire

// ==== tb/two_way_cache_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

// protocol checks on the cache's external handshakes
module two_way_cache_chk (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid,
	input  logic req_ready,
	input  logic resp_valid,
	input  logic mem_rd_valid,
	input  logic mem_rd_ready,
	input  logic [cache_pkg::block_w-1:0] mem_rd_addr,
	input  logic mem_wr_valid,
	input  logic mem_wr_ready,
	input  logic [cache_pkg::addr_w-1:0] mem_wr_addr,
	input  logic [cache_pkg::data_w-1:0] mem_wr_data
);

	// number of failed assertions so far
	int fail_count = 0;

	// a fill request keeps its block address until memory takes it
	rd_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rd_valid && !mem_rd_ready |=> mem_rd_valid && $stable(mem_rd_addr))
	else begin
		$error("fill request dropped or changed before mem_rd_ready");
		fail_count++;
	end

	// a memory write holds address and data until it is taken
	wr_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		mem_wr_valid && !mem_wr_ready |=>
		mem_wr_valid && $stable(mem_wr_addr) && $stable(mem_wr_data))
	else begin
		$error("memory write dropped or changed before mem_wr_ready");
		fail_count++;
	end

	// a response only comes while the controller is busy
	resp_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
		!(resp_valid && req_ready))
	else begin
		$error("resp_valid high while req_ready is high");
		fail_count++;
	end

	// the cycle after a reset edge shows no valid on any handshake
	reset_quiet_a: assert property (@(posedge clk)
		!rst_n |=> !(resp_valid || mem_rd_valid || mem_wr_valid || req_valid))
	else begin
		$error("handshake valid high right after a reset edge");
		fail_count++;
	end

endmodule

bind two_way_cache two_way_cache_chk i_two_way_cache_chk (
	.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_ready(req_ready),
	.resp_valid(resp_valid), .mem_rd_valid(mem_rd_valid), .mem_rd_ready(mem_rd_ready),
	.mem_rd_addr(mem_rd_addr), .mem_wr_valid(mem_wr_valid), .mem_wr_ready(mem_wr_ready),
	.mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data)
);

`default_nettype wire

// ==== tb/two_way_cache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module two_way_cache_tb;

	import cache_pkg::*;

	// requests of the directed tests plus the random mix
	localparam int mix_requests = 300;
	localparam int num_requests = 2 + 6 + 3 + 2 + mix_requests;
	localparam int max_cycles = 40 * num_requests + 10;

	logic clk;
	logic rst_n;
	logic req_valid;
	logic req_ready;
	logic req_we;
	logic [addr_w-1:0] req_addr;
	logic [data_w-1:0] req_wdata;
	logic resp_valid;
	logic [data_w-1:0] resp_rdata;
	logic mem_rd_valid;
	logic mem_rd_ready;
	logic [block_w-1:0] mem_rd_addr;
	logic mem_fill_valid;
	logic [data_w-1:0] mem_fill_data;
	logic mem_wr_valid;
	logic mem_wr_ready;
	logic [addr_w-1:0] mem_wr_addr;
	logic [data_w-1:0] mem_wr_data;

	int seed = 32;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	// handshake counters kept by the monitor
	int fill_count = 0;
	int wr_count = 0;
	int fill_base = 0;
	int wr_base = 0;
	int accept_cycle = 0;
	int resp_count = 0;
	int ref_fills = 0;
	int total_errors;
	string test_name = "after_reset";

	// backing memory as the cache sees it, and the model's own copy
	logic [data_w-1:0] mem_words [2**addr_w];
	logic [data_w-1:0] ref_mem [2**addr_w];
	logic ref_valid [2][num_sets];
	logic [tag_w-1:0] ref_tag [2][num_sets];
	// names the least recently used way of each set
	logic ref_lru [num_sets];

	logic [data_w-1:0] exp_data_q [$];
	logic exp_fill_q [$];
	logic exp_we_q [$];

	two_way_cache #(
		.num_sets(num_sets),
		.words_per_block(words_per_block)
	) i_two_way_cache (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// a rotation of the whole address, so no two words start out equal
	function automatic logic [data_w-1:0] mem_pattern(input logic [addr_w-1:0] a);
		return {a[6:0], a[15:7]} ^ 16'h3c5a;
	endfunction

	function automatic logic [addr_w-1:0] make_addr(input int t, input int s, input int o);
		return {t[tag_w-1:0], s[set_w-1:0], o[offset_w-1:0]};
	endfunction

	// the expected response of one request; fill tells whether a block load is due
	function automatic logic [data_w-1:0] ref_access(input logic we, input logic [addr_w-1:0] a,
			input logic [data_w-1:0] wdata, output logic fill);
		logic [tag_w-1:0] t;
		int s;
		int way;
		t = a[addr_w-1 -: tag_w];
		s = a[offset_w +: set_w];
		way = -1;
		fill = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (ref_valid[w][s] && ref_tag[w][s] == t) begin
				way = w;
			end
		end
		if (way >= 0) begin
			ref_lru[s] = (way == 0);
		end else if (!we) begin
			// empty way 0, then empty way 1, then the least recently used one
			way = !ref_valid[0][s] ? 0 : (!ref_valid[1][s] ? 1 : int'(ref_lru[s]));
			ref_valid[way][s] = 1'b1;
			ref_tag[way][s] = t;
			ref_lru[s] = (way == 0);
			fill = 1'b1;
			ref_fills++;
		end
		// writes always reach memory and answer with zero
		if (we) begin
			ref_mem[a] = wdata;
			return '0;
		end
		return ref_mem[a];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	// one request, from the handshake up to its response
	task automatic issue(input logic we, input logic [addr_w-1:0] a, input logic [data_w-1:0] wdata);
		logic fill;
		logic [data_w-1:0] expected;
		int resp_before;
		expected = ref_access(we, a, wdata, fill);
		exp_data_q.push_back(expected);
		exp_fill_q.push_back(fill);
		exp_we_q.push_back(we);
		resp_before = resp_count;
		@(negedge clk);
		while (!req_ready) @(negedge clk);
		req_valid = 1'b1;
		req_we = we;
		req_addr = a;
		req_wdata = wdata;
		@(negedge clk);
		req_valid = 1'b0;
		req_we = 1'b0;
		while (resp_count == resp_before) @(negedge clk);
	endtask

	task automatic finish_test(input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - errors_before);
		end
	endtask

	task automatic compare_response();
		logic [data_w-1:0] exp_data;
		logic exp_fill;
		logic exp_we;
		if (exp_data_q.size() == 0) begin
			$display("error in %s: response without an outstanding request", test_name);
			errors++;
			return;
		end
		exp_data = exp_data_q.pop_front();
		exp_fill = exp_fill_q.pop_front();
		exp_we = exp_we_q.pop_front();
		check_value({test_name, " data"}, exp_data, resp_rdata);
		check_value({test_name, " fills"}, exp_fill, fill_count - fill_base);
		check_value({test_name, " memory writes"}, exp_we, wr_count - wr_base);
		// a read hit answers exactly two cycles after acceptance
		if (!exp_we && !exp_fill) begin
			check_value({test_name, " hit latency"}, 2, cycles - accept_cycle);
		end
		resp_count++;
	endtask

	always @(posedge clk) begin : monitor
		cycles = cycles + 1;
		if (rst_n === 1'b1) begin
			if (mem_rd_valid && mem_rd_ready) fill_count = fill_count + 1;
			if (mem_wr_valid && mem_wr_ready) wr_count = wr_count + 1;
			if (req_valid && req_ready) begin
				accept_cycle = cycles;
				fill_base = fill_count;
				wr_base = wr_count;
			end
			if (resp_valid) compare_response();
		end
	end

	// memory answers after 0 to 3 idle cycles and may pause between beats
	initial begin : memory_model
		logic [block_w-1:0] blk;
		mem_rd_ready = 1'b0;
		mem_fill_valid = 1'b0;
		mem_fill_data = '0;
		mem_wr_ready = 1'b0;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk);
			if (mem_rd_valid) begin
				repeat ($random(seed) & 3) @(negedge clk);
				mem_rd_ready = 1'b1;
				blk = mem_rd_addr;
				@(negedge clk);
				mem_rd_ready = 1'b0;
				for (int w = 0; w < words_per_block; w++) begin
					if ($random(seed) & 1) begin
						mem_fill_valid = 1'b0;
						@(negedge clk);
					end
					mem_fill_valid = 1'b1;
					mem_fill_data = mem_words[{blk, offset_w'(w)}];
					@(negedge clk);
				end
				mem_fill_valid = 1'b0;
			end else if (mem_wr_valid) begin
				repeat ($random(seed) & 3) @(negedge clk);
				mem_wr_ready = 1'b1;
				mem_words[mem_wr_addr] = mem_wr_data;
				@(negedge clk);
				mem_wr_ready = 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (cycles >= max_cycles);
		$display("timeout: the run did not finish within %0d cycles", max_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin : stimulus
		int errors_before;
		int fills_before;
		int ref_fills_before;
		logic [addr_w-1:0] a;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_we = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		for (int i = 0; i < 2**addr_w; i++) begin
			mem_words[i] = mem_pattern(i);
			ref_mem[i] = mem_pattern(i);
		end
		for (int s = 0; s < num_sets; s++) begin
			ref_valid[0][s] = 1'b0;
			ref_valid[1][s] = 1'b0;
			ref_lru[s] = 1'b0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		errors_before = errors;
		check_value("after_reset req_ready", 1, req_ready);
		check_value("after_reset valids", 0, {resp_valid, mem_rd_valid, mem_wr_valid});
		finish_test(errors_before);

		test_name = "cold_miss_then_hit";
		errors_before = errors;
		issue(1'b0, make_addr(3, 1, 2), '0);
		issue(1'b0, make_addr(3, 1, 6), '0);
		finish_test(errors_before);

		// blocks a, b and c share set 5, so c has to push one of the others out
		test_name = "lru_eviction";
		errors_before = errors;
		issue(1'b0, make_addr(10, 5, 0), '0);
		issue(1'b0, make_addr(11, 5, 3), '0);
		issue(1'b0, make_addr(10, 5, 1), '0);
		issue(1'b0, make_addr(12, 5, 7), '0);
		issue(1'b0, make_addr(10, 5, 2), '0);
		issue(1'b0, make_addr(11, 5, 4), '0);
		finish_test(errors_before);

		test_name = "write_hit";
		errors_before = errors;
		a = make_addr(20, 9, 4);
		issue(1'b0, a, '0);
		issue(1'b1, a, 16'hbeef);
		check_value("write_hit memory word", 16'hbeef, mem_words[a]);
		issue(1'b0, a, '0);
		finish_test(errors_before);

		test_name = "write_miss";
		errors_before = errors;
		a = make_addr(30, 12, 1);
		issue(1'b1, a, 16'h1234);
		issue(1'b0, a, '0);
		finish_test(errors_before);

		// four tags over two sets keep both ways busy and force evictions
		test_name = "random_mix";
		errors_before = errors;
		fills_before = fill_count;
		ref_fills_before = ref_fills;
		repeat (mix_requests) begin
			a = make_addr(40 + ($random(seed) & 3), 20 + ($random(seed) & 1), $random(seed) & 7);
			if (($random(seed) & 3) == 0) begin
				issue(1'b1, a, data_w'($random(seed)));
			end else begin
				issue(1'b0, a, '0);
			end
		end
		check_value("random_mix total fills", ref_fills - ref_fills_before,
			fill_count - fills_before);
		finish_test(errors_before);

		total_errors = errors + i_two_way_cache.i_two_way_cache_chk.fail_count;
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests_run, tests_failed, checks, errors, i_two_way_cache.i_two_way_cache_chk.fail_count);
		if (total_errors == 0 && tests_failed == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== two_way_cache.f ====
common/cache_pkg.sv
rtl/addr_decode.sv
cache_array/lru_array.sv
cache_array/tag_array.sv
cache_array/data_array.sv
rtl/cache_ctrl.sv
rtl/two_way_cache.sv
tb/two_way_cache_chk.sv
tb/two_way_cache_tb.sv
